// ==== cam_capture_top.f ====
rtl/cam_geom_pkg.sv
rtl/pixel_pkg.sv
rtl/rgb565_assembler.sv
rtl/box2x2_decimator.sv
rtl/fb_write_addr.sv
rtl/frame_buffer.sv
rtl/cam_capture_top.sv
tb/cam_capture_tb.sv

// ==== rtl/box2x2_decimator.sv ====
// horizontal pair sums, even-line buffer, 2x2 truncating average
`timescale 1ns/1ns
`default_nettype none

module box2x2_decimator
    import cam_geom_pkg::*;
    import pixel_pkg::*;
(
    input  logic     pclk,
    input  logic     rst_n,
    input  logic     pix_valid,
    input  pix_evt_t pix_evt,
    input  logic     line_start,
    input  logic     line_end,
    input  logic     frame_start,
    output logic     dec_valid,
    output dec_out_t dec_out
);

    pair_sum_t line_buf [DST_H];   // pair sums of the last even line

    rgb565_t   p0;                 // first pixel of the current pair
    logic      have_p0;
    dst_x_t    pair_idx;
    dst_y_t    row;
    logic      last_odd;           // parity of the line being received
    pair_sum_t h_sum;
    pair_sum_t prev_sum;
    quad_sum_t q_sum;
    rgb565_t   avg;
    logic      row_ok;

    always_comb begin
        h_sum.r = 6'(p0.r) + 6'(pix_evt.pix.r);
        h_sum.g = 7'(p0.g) + 7'(pix_evt.pix.g);
        h_sum.b = 6'(p0.b) + 6'(pix_evt.pix.b);

        prev_sum = line_buf[pair_idx];

        q_sum.r = 7'(prev_sum.r) + 7'(h_sum.r);
        q_sum.g = 8'(prev_sum.g) + 8'(h_sum.g);
        q_sum.b = 7'(prev_sum.b) + 7'(h_sum.b);

        // truncating divide by 4
        avg.g = q_sum.g[7:2];
        if (BGR_ORDER) begin
            avg.r = q_sum.b[6:2];
            avg.b = q_sum.r[6:2];
        end else begin
            avg.r = q_sum.r[6:2];
            avg.b = q_sum.b[6:2];
        end
    end

    assign row_ok = (row < DST_V) && (pix_evt.y < SRC_V);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            have_p0   <= 1'b0;
            pair_idx  <= '0;
            row       <= '0;
            last_odd  <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= 1'b0;

            if (frame_start) begin
                row      <= '0;
                last_odd <= 1'b0;
            end else if (line_end && last_odd && row < DST_V - 1) begin
                row <= row + 1'b1;   // one output row per odd line
            end

            if (line_start) begin
                have_p0  <= 1'b0;
                pair_idx <= '0;
            end else if (pix_valid) begin
                have_p0  <= ~have_p0;
                last_odd <= pix_evt.line_odd;
                if (have_p0) begin
                    pair_idx  <= pair_idx + 1'b1;
                    dec_valid <= pix_evt.line_odd && row_ok;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (pix_valid && !have_p0)
            p0 <= pix_evt.pix;
        if (pix_valid && have_p0 && !pix_evt.line_odd)
            line_buf[pair_idx] <= h_sum;   // keep the pair sum of an even line
        if (pix_valid && have_p0) begin
            dec_out.pix <= avg;
            dec_out.row <= row;
        end
    end

    assert property (@(posedge pclk) disable iff (!rst_n)
        pix_valid && have_p0 |-> pair_idx < DST_H);

    // pairing here must agree with the column count of the assembler
    assert property (@(posedge pclk) disable iff (!rst_n)
        pix_valid && !line_start |-> pix_evt.x[0] == have_p0);

endmodule

`default_nettype wire

// ==== rtl/cam_capture_top.sv ====
// camera capture chain with 2x2 decimation into the frame buffer
`timescale 1ns/1ns
`default_nettype none

module cam_capture_top
    import cam_geom_pkg::*;
    import pixel_pkg::*;
(
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      vsync,
    input  logic      href,
    input  cam_byte_t d,
    input  fb_addr_t  rd_addr,
    output rgb565_t   rd_data
);

    logic     pix_valid;
    pix_evt_t pix_evt;
    logic     line_start;
    logic     line_end;
    logic     frame_start;
    logic     dec_valid;
    dec_out_t dec_out;
    logic     we;
    fb_addr_t wr_addr;
    rgb565_t  wr_data;

    rgb565_assembler u_asm (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .vsync       (vsync),
        .href        (href),
        .d           (d),
        .pix_valid   (pix_valid),
        .pix_evt     (pix_evt),
        .line_start  (line_start),
        .line_end    (line_end),
        .frame_start (frame_start)
    );

    box2x2_decimator u_dec (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .pix_valid   (pix_valid),
        .pix_evt     (pix_evt),
        .line_start  (line_start),
        .line_end    (line_end),
        .frame_start (frame_start),
        .dec_valid   (dec_valid),
        .dec_out     (dec_out)
    );

    fb_write_addr u_wa (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_out     (dec_out),
        .line_start  (line_start),
        .line_end    (line_end),
        .frame_start (frame_start),
        .we          (we),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    frame_buffer u_fb (
        .pclk    (pclk),
        .we      (we),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== rtl/cam_geom_pkg.sv ====
// frame geometry, line skip count, coordinate and address types
`default_nettype none

package cam_geom_pkg;

    // source frame from the camera
    localparam integer SRC_H = 640;
    localparam integer SRC_V = 480;

    // decimated frame held in the buffer
    localparam integer DST_H = 320;
    localparam integer DST_V = 240;

    // source pixels ignored at each line start
    localparam integer LINE_SKIP_PIXELS = 3;

    // masked outputs per line, rounded up
    localparam integer OUT_SKIP = (LINE_SKIP_PIXELS + 1) / 2;

    localparam integer FB_DEPTH = DST_H * DST_V;

    typedef logic [9:0]  src_x_t;     // 0..SRC_H, saturates at SRC_H
    typedef logic [8:0]  src_y_t;     // 0..SRC_V
    typedef logic [8:0]  dst_x_t;     // pair index, also writes per line
    typedef logic [7:0]  dst_y_t;
    typedef logic [16:0] fb_addr_t;
    typedef logic [9:0]  skip_cnt_t;

endpackage

`default_nettype wire

// ==== rtl/fb_write_addr.sv ====
// output masking, write address counter, end-of-odd-line realignment
`timescale 1ns/1ns
`default_nettype none

module fb_write_addr
    import cam_geom_pkg::*;
    import pixel_pkg::*;
(
    input  logic     pclk,
    input  logic     rst_n,
    input  logic     dec_valid,
    input  dec_out_t dec_out,
    input  logic     line_start,
    input  logic     line_end,
    input  logic     frame_start,
    output logic     we,
    output fb_addr_t wr_addr,
    output rgb565_t  wr_data
);

    skip_cnt_t skip_cnt;    // outputs still to be masked on this line
    dst_x_t    wcount;      // writes on the current line
    fb_addr_t  nxt_addr;
    logic      line_odd;
    logic      accept;
    fb_addr_t  row_base;

    assign accept   = dec_valid && (skip_cnt == '0);
    assign row_base = fb_addr_t'(dec_out.row) * fb_addr_t'(DST_H);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            skip_cnt <= '0;
            wcount   <= '0;
            nxt_addr <= '0;
            line_odd <= 1'b0;
            we       <= 1'b0;
            wr_addr  <= '0;
        end else begin
            we <= accept;
            if (frame_start) begin
                skip_cnt <= '0;
                wcount   <= '0;
                nxt_addr <= '0;
                line_odd <= 1'b0;
                wr_addr  <= '0;
            end else begin
                if (line_start)
                    skip_cnt <= skip_cnt_t'(OUT_SKIP);
                else if (dec_valid && skip_cnt != '0)
                    skip_cnt <= skip_cnt - 1'b1;   // masked output leaves the address

                if (accept)
                    wr_addr <= nxt_addr;

                if (line_end)
                    line_odd <= ~line_odd;

                // a write in the same cycle cancels out of the jump
                if (line_end && line_odd) begin
                    nxt_addr <= nxt_addr + fb_addr_t'(DST_H) - fb_addr_t'(wcount);
                    wcount   <= '0;
                end else if (accept) begin
                    nxt_addr <= nxt_addr + 1'b1;
                    wcount   <= wcount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (accept)
            wr_data <= dec_out.pix;
    end

    assert property (@(posedge pclk) disable iff (!rst_n) we |-> wr_addr < FB_DEPTH);

    // each write lands inside the row the decimator is producing
    assert property (@(posedge pclk) disable iff (!rst_n)
        accept |-> nxt_addr >= row_base && nxt_addr < row_base + DST_H);

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
// simple dual-port rgb565 RAM, one write port, registered read port
`timescale 1ns/1ns
`default_nettype none

module frame_buffer
    import cam_geom_pkg::*;
    import pixel_pkg::*;
(
    input  logic     pclk,
    input  logic     we,
    input  fb_addr_t wr_addr,
    input  rgb565_t  wr_data,
    input  fb_addr_t rd_addr,
    output rgb565_t  rd_data
);

    rgb565_t mem [FB_DEPTH];   // DST_H x DST_V words in row-major order

    always_ff @(posedge pclk) begin
        if (we)
            mem[wr_addr] <= wr_data;
    end

    // one cycle read latency
    always_ff @(posedge pclk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== rtl/pixel_pkg.sv ====
// byte and colour order constants, rgb565 and sum structs, stage payload structs
`default_nettype none

package pixel_pkg;

    import cam_geom_pkg::*;

    localparam bit HI_BYTE_FIRST = 1'b1;   // camera sends bits [15:8] first
    localparam bit BGR_ORDER     = 1'b0;   // 1 swaps red and blue on output

    typedef logic [7:0] cam_byte_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // sum of two horizontal neighbours, one bit of growth per channel
    typedef struct packed {
        logic [5:0] r;
        logic [6:0] g;
        logic [5:0] b;
    } pair_sum_t;

    // sum of a full 2x2 block
    typedef struct packed {
        logic [6:0] r;
        logic [7:0] g;
        logic [6:0] b;
    } quad_sum_t;

    // assembler -> decimator
    typedef struct packed {
        rgb565_t pix;
        src_x_t  x;
        logic    line_odd;
        src_y_t  y;
    } pix_evt_t;

    // decimator -> address generator
    typedef struct packed {
        rgb565_t pix;
        dst_y_t  row;
    } dec_out_t;

endpackage

`default_nettype wire

// ==== rtl/rgb565_assembler.sv ====
// sync edge detect, byte pairing, source coordinates, event strobes
`timescale 1ns/1ns
`default_nettype none

module rgb565_assembler
    import cam_geom_pkg::*;
    import pixel_pkg::*;
(
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      vsync,
    input  logic      href,
    input  cam_byte_t d,
    output logic      pix_valid,
    output pix_evt_t  pix_evt,
    output logic      line_start,
    output logic      line_end,
    output logic      frame_start
);

    logic        vsync_d;
    logic        href_d;
    logic        vsync_rise;
    logic        href_rise;
    logic        href_fall;
    logic        byte_phase;   // high while waiting for the second byte
    cam_byte_t   first_byte;
    src_x_t      col;
    src_y_t      row;
    logic [15:0] word;

    assign vsync_rise = vsync & ~vsync_d;
    assign href_rise  = href & ~href_d;
    assign href_fall  = ~href & href_d;

    assign word = HI_BYTE_FIRST ? {first_byte, d} : {d, first_byte};

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            vsync_d     <= 1'b0;
            href_d      <= 1'b0;
            line_start  <= 1'b0;
            line_end    <= 1'b0;
            frame_start <= 1'b0;
            byte_phase  <= 1'b0;
            col         <= '0;
            row         <= '0;
            pix_valid   <= 1'b0;
        end else begin
            vsync_d     <= vsync;
            href_d      <= href;
            line_start  <= href_rise;
            line_end    <= href_fall;
            frame_start <= vsync_rise;
            pix_valid   <= 1'b0;

            // row and parity follow the href falling edges
            if (vsync_rise)
                row <= '0;
            else if (href_fall && row < SRC_V)
                row <= row + 1'b1;

            if (!href) begin
                byte_phase <= 1'b0;  // pairing restarts with the next line
                col        <= '0;
            end else begin
                byte_phase <= ~byte_phase;
                if (byte_phase && col < SRC_H) begin
                    col       <= col + 1'b1;
                    pix_valid <= (row < SRC_V);  // lines past the frame are dropped
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (href && !byte_phase)
            first_byte <= d;
        if (href && byte_phase) begin
            pix_evt.pix      <= rgb565_t'(word);
            pix_evt.x        <= col;
            pix_evt.line_odd <= row[0];
            pix_evt.y        <= row;
        end
    end

    // the camera needs two cycles per pixel
    assert property (@(posedge pclk) disable iff (!rst_n) pix_valid |=> !pix_valid);

endmodule

`default_nettype wire

// ==== tb/cam_capture_tb.sv ====
// camera byte stimulus, 2x2 average and address model, directed tests, watchdog
`timescale 1ns/1ns
`default_nettype none

module cam_capture_tb
    import cam_geom_pkg::*;
    import pixel_pkg::*;
;

    localparam integer CLK_PERIOD  = 8;
    localparam integer LINE_GAP    = 16;
    localparam integer LINE_CYCLES = 2 * SRC_H + LINE_GAP;
    localparam integer N_LINES     = 13;   // lines sent over all tests
    localparam integer WATCHDOG_NS = N_LINES * LINE_CYCLES * CLK_PERIOD * 3 / 2;
    localparam logic [15:0] FLAT_PIX = 16'hb5a6;

    logic      pclk = 1'b0;
    logic      rst_n;
    logic      vsync;
    logic      href;
    cam_byte_t d;
    fb_addr_t  rd_addr;
    rgb565_t   rd_data;

    rgb565_t   frame_pix [0:4][0:SRC_H-1];   // source lines with index 4 for the lone even line
    integer    seed = 32'h0c36_1ff1;
    rgb565_t   tail_lo;                      // never written so kept from the first frame
    rgb565_t   tail_hi;

    cam_capture_top dut0 (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .vsync   (vsync),
        .href    (href),
        .d       (d),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    always #(CLK_PERIOD / 2) pclk = ~pclk;

    // truncated per-channel mean of a 2x2 block
    function automatic rgb565_t box_average(input rgb565_t p0, input rgb565_t p1,
                                            input rgb565_t p2, input rgb565_t p3);
        integer  r_sum;
        integer  g_sum;
        integer  b_sum;
        rgb565_t res;
        r_sum = p0.r + p1.r + p2.r + p3.r;
        g_sum = p0.g + p1.g + p2.g + p3.g;
        b_sum = p0.b + p1.b + p2.b + p3.b;
        res.g = g_sum / 4;
        if (BGR_ORDER) begin
            res.r = b_sum / 4;
            res.b = r_sum / 4;
        end else begin
            res.r = r_sum / 4;
            res.b = b_sum / 4;
        end
        return res;
    endfunction

    // masked outputs shift the row left
    function automatic fb_addr_t block_addr(input integer row, input integer k);
        return fb_addr_t'(row * DST_H + k - OUT_SKIP);
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%04h, expected 0x%04h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fill_random(input integer line);
        integer      x;
        logic [31:0] rnd;
        for (x = 0; x < SRC_H; x++) begin
            rnd = $random(seed);
            frame_pix[line][x] = rnd[15:0];
        end
    endtask

    task automatic fill_flat(input integer line, input logic [15:0] value);
        integer x;
        for (x = 0; x < SRC_H; x++)
            frame_pix[line][x] = value;
    endtask

    task automatic send_frame_start();
        @(negedge pclk);
        vsync = 1'b1;
        repeat (3) @(negedge pclk);
        vsync = 1'b0;
        repeat (8) @(negedge pclk);
    endtask

    // two bytes per pixel with the high byte first and an idle gap after
    task automatic send_line(input integer line);
        integer      x;
        logic [15:0] w;
        for (x = 0; x < SRC_H; x++) begin
            w = frame_pix[line][x];
            @(negedge pclk);
            href = 1'b1;
            d    = w[15:8];
            @(negedge pclk);
            d    = w[7:0];
        end
        @(negedge pclk);
        href = 1'b0;
        d    = '0;
        repeat (LINE_GAP) @(negedge pclk);
    endtask

    task automatic read_word(input fb_addr_t addr, output rgb565_t data);
        @(negedge pclk);
        rd_addr = addr;
        @(negedge pclk);   // registered read
        data = rd_data;
    endtask

    // every written word of one output row against the model
    task automatic check_row(input integer out_row, input integer even_line);
        integer   k;
        fb_addr_t addr;
        rgb565_t  got;
        rgb565_t  exp;
        for (k = OUT_SKIP; k < DST_H; k++) begin
            addr = block_addr(out_row, k);
            exp  = box_average(frame_pix[even_line][2*k], frame_pix[even_line][2*k+1],
                               frame_pix[even_line+1][2*k], frame_pix[even_line+1][2*k+1]);
            read_word(addr, got);
            check($sformatf("rd_data @%0d", addr), got, exp);
        end
    endtask

    task automatic check_tail();
        rgb565_t got;
        read_word(fb_addr_t'(DST_H - 2), got);
        check("rd_data tail DST_H-2", got, tail_lo);
        read_word(fb_addr_t'(DST_H - 1), got);
        check("rd_data tail DST_H-1", got, tail_hi);
    endtask

    task automatic flat_colour_test();
        integer  a;
        rgb565_t got;
        send_frame_start();
        fill_flat(0, FLAT_PIX);
        fill_flat(1, FLAT_PIX);
        send_line(0);
        send_line(1);
        for (a = 0; a < DST_H - OUT_SKIP; a++) begin
            read_word(fb_addr_t'(a), got);
            check($sformatf("rd_data @%0d", a), got, FLAT_PIX);
        end
        read_word(fb_addr_t'(DST_H - 2), tail_lo);
        read_word(fb_addr_t'(DST_H - 1), tail_hi);
    endtask

    task automatic random_average_test();
        send_frame_start();
        fill_random(0);
        fill_random(1);
        send_line(0);
        send_line(1);
        check_row(0, 0);
    endtask

    task automatic row_alignment_test();
        integer i;
        send_frame_start();
        for (i = 0; i < 4; i++) begin
            fill_random(i);
            send_line(i);
        end
        check_row(1, 2);   // second output row starts at DST_H
        check_tail();
    endtask

    // lines 0 and 1 still describe row 0 from the previous frame
    task automatic even_line_only_test();
        send_frame_start();
        fill_random(4);
        send_line(4);
        send_frame_start();
        check_row(0, 0);
    endtask

    task automatic frame_restart_test();
        fill_random(0);
        fill_random(1);
        send_line(0);
        send_line(1);
        check_row(0, 0);
    endtask

    task automatic masked_tail_test();
        integer x;
        send_frame_start();
        fill_random(0);
        fill_random(1);
        for (x = SRC_H - 2; x < SRC_H; x++) begin
            frame_pix[0][x] = ~FLAT_PIX;   // last block surely differs
            frame_pix[1][x] = ~FLAT_PIX;
        end
        send_line(0);
        send_line(1);
        check_row(0, 0);
        check_tail();
    endtask

    initial begin
        rst_n   = 1'b0;
        vsync   = 1'b0;
        href    = 1'b0;
        d       = '0;
        rd_addr = '0;
        repeat (10) @(negedge pclk);
        rst_n = 1'b1;
        repeat (4) @(negedge pclk);

        flat_colour_test();
        $display("flat colour done");
        random_average_test();
        $display("random averaging done");
        row_alignment_test();
        $display("row alignment done");
        even_line_only_test();
        $display("even line alone done");
        frame_restart_test();
        $display("frame restart done");
        masked_tail_test();
        $display("masked tail done");

        $display("TEST RESULT: PASS");
        $finish;
    end

    // all lines plus half again
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
